// ==== Makefile ====
# Verilator flow for the stepper motor axis.

TOP       ?= tb_motor_top
BUILD_DIR ?= build
FILELIST  ?= compile.f
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run fails with a non-zero exit status on any fatal error.
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
+incdir+rtl
rtl/motor_pkg.sv
rtl/motor_regs.sv
rtl/move_ctl.sv
rtl/step_gen.sv
rtl/motor_top.sv
sim/motor_props.sv
sim/tb_motor_top.sv

// ==== rtl/motor_defs.svh ====
`ifndef MOTOR_DEFS_SVH
`define MOTOR_DEFS_SVH

// --------------------------------------------------------------------------
// axis widths.
// --------------------------------------------------------------------------

`define MOTOR_SPEED_W 16 // step period in clock cycles.
`define MOTOR_STEP_W  16 // steps per move.
`define MOTOR_POS_W   32 // signed absolute position.

// --------------------------------------------------------------------------
// wishbone bus.
// --------------------------------------------------------------------------

`define WB_ADR_W 3 // word address.
`define WB_DAT_W 32

`endif

// ==== rtl/motor_pkg.sv ====
`include "motor_defs.svh"

package motor_pkg;

	// one move as programmed by the bus master.
	typedef struct packed {
		logic                      dir; // 1 is backward, toward home.
		logic [`MOTOR_SPEED_W-1:0] speed;
		logic [`MOTOR_STEP_W-1:0]  steps;
	} move_req_t;

	typedef struct packed {
		logic busy;
		logic done;
		logic limit_hit;
		logic aborted;
	} move_status_t;

	typedef enum logic [1:0] {
		IDLE,
		LAUNCH,
		RUN,
		FINISH
	} move_state_e;

	// register map, word addresses.
	typedef enum logic [`WB_ADR_W-1:0] {
		REG_CTRL     = 3'd0,
		REG_SPEED    = 3'd1,
		REG_STEPS    = 3'd2,
		REG_DIR      = 3'd3,
		REG_STATUS   = 3'd4,
		REG_POSITION = 3'd5
	} reg_addr_e;

endpackage

// ==== rtl/motor_regs.sv ====
`timescale 1ns/1ps
`include "motor_defs.svh"

module motor_regs
	import motor_pkg::*;
(
	input  logic                     clk,
	input  logic                     resetn,

	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [`WB_ADR_W-1:0]     wb_adr,
	input  logic [`WB_DAT_W-1:0]     wb_dat_w,
	output logic [`WB_DAT_W-1:0]     wb_dat_r,
	output logic                     wb_ack,

	output move_req_t                req,
	output logic                     go,
	output logic                     abort,
	input  move_status_t             status,
	input  logic [`MOTOR_POS_W-1:0]  position
);

	logic      wb_req;
	logic      wr_en;
	logic      ctrl_wr;
	reg_addr_e addr;

	assign wb_req  = wb_cyc & wb_stb & ~wb_ack; // a request not yet acked.
	assign wr_en   = wb_req & wb_we;
	assign addr    = reg_addr_e'(wb_adr);
	assign ctrl_wr = wr_en && (addr == REG_CTRL);

	// --------------------------------------------------------------------------
	// bus handshake and command pulses.
	// --------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wb_ack <= 1'b0;
			go     <= 1'b0;
			abort  <= 1'b0;
		end else begin
			wb_ack <= wb_req;
			go     <= ctrl_wr & wb_dat_w[0];
			abort  <= ctrl_wr & wb_dat_w[1];
		end
	end

	// --------------------------------------------------------------------------
	// move request registers.
	// --------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!resetn) begin
			req <= '0;
		end else if (wr_en) begin
			case (addr)
				REG_SPEED: req.speed <= wb_dat_w[`MOTOR_SPEED_W-1:0];
				REG_STEPS: req.steps <= wb_dat_w[`MOTOR_STEP_W-1:0];
				REG_DIR:   req.dir   <= wb_dat_w[0];
				default: ; // ctrl and read only registers.
			endcase
		end
	end

	// read data, valid together with ack.
	always_ff @(posedge clk) begin
		if (wb_req && !wb_we) begin
			case (addr)
				REG_SPEED:    wb_dat_r <= `WB_DAT_W'(req.speed);
				REG_STEPS:    wb_dat_r <= `WB_DAT_W'(req.steps);
				REG_DIR:      wb_dat_r <= `WB_DAT_W'(req.dir);
				REG_STATUS:   wb_dat_r <= `WB_DAT_W'(status);
				REG_POSITION: wb_dat_r <= `WB_DAT_W'(position);
				default:      wb_dat_r <= '0;
			endcase
		end
	end

endmodule

// ==== rtl/motor_top.sv ====
`timescale 1ns/1ps
`include "motor_defs.svh"

module motor_top
	import motor_pkg::*;
(
	input  logic                 clk,
	input  logic                 resetn,

	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [`WB_ADR_W-1:0] wb_adr,
	input  logic [`WB_DAT_W-1:0] wb_dat_w,
	output logic [`WB_DAT_W-1:0] wb_dat_r,
	output logic                 wb_ack,

	output logic                 step_pulse,
	output logic                 step_dir,
	input  logic                 home_limit,
	input  logic                 end_limit
);

	move_req_t                      req_regs;
	move_req_t                      req_move;
	move_status_t                   status;
	logic                           go;
	logic                           abort;
	logic                           start;
	logic                           stop;
	logic                           running;
	logic                           limit_stop;
	logic signed [`MOTOR_POS_W-1:0] position;

	motor_regs u_regs (
		.clk      (clk),
		.resetn   (resetn),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.req      (req_regs),
		.go       (go),
		.abort    (abort),
		.status   (status),
		.position (position)
	);

	move_ctl u_move (
		.clk        (clk),
		.resetn     (resetn),
		.req_in     (req_regs),
		.go         (go),
		.abort      (abort),
		.status     (status),
		.start      (start),
		.stop       (stop),
		.req_out    (req_move),
		.running    (running),
		.limit_stop (limit_stop)
	);

	step_gen u_step (
		.clk        (clk),
		.resetn     (resetn),
		.start      (start),
		.stop       (stop),
		.req        (req_move),
		.running    (running),
		.limit_stop (limit_stop),
		.step_pulse (step_pulse),
		.step_dir   (step_dir),
		.home_limit (home_limit),
		.end_limit  (end_limit),
		.position   (position)
	);

endmodule

// ==== rtl/move_ctl.sv ====
`timescale 1ns/1ps
`include "motor_defs.svh"

module move_ctl
	import motor_pkg::*;
(
	input  logic         clk,
	input  logic         resetn,

	input  move_req_t    req_in,
	input  logic         go,
	input  logic         abort,
	output move_status_t status,

	output logic         start,
	output logic         stop,
	output move_req_t    req_out,
	input  logic         running,
	input  logic         limit_stop
);

	move_state_e state;
	logic        run_seen; // running has been high in this move.
	logic        limit_hit;
	logic        aborted;
	logic        launch;

	assign launch = go && ((state == IDLE) || (state == FINISH));

	always_ff @(posedge clk) begin
		if (launch)
			req_out <= req_in;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= IDLE;
			start     <= 1'b0;
			stop      <= 1'b0;
			run_seen  <= 1'b0;
			limit_hit <= 1'b0;
			aborted   <= 1'b0;
		end else begin
			start <= 1'b0;
			stop  <= 1'b0;
			case (state)
				IDLE, FINISH: begin
					if (launch) begin
						state     <= LAUNCH;
						limit_hit <= 1'b0;
						aborted   <= 1'b0;
					end
				end
				LAUNCH: begin
					if (abort) begin // give up before the generator starts.
						state   <= FINISH;
						aborted <= 1'b1;
					end else begin
						start    <= 1'b1;
						run_seen <= 1'b0;
						state    <= RUN;
					end
				end
				RUN: begin
					if (running)
						run_seen <= 1'b1;
					if (abort && !aborted) begin
						stop    <= 1'b1; // forwarded to step_gen.
						aborted <= 1'b1;
					end
					if (limit_stop)
						limit_hit <= 1'b1;
					if (run_seen && !running)
						state <= FINISH;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_comb begin
		status.busy      = (state == LAUNCH) || (state == RUN);
		status.done      = (state == FINISH);
		status.limit_hit = limit_hit;
		status.aborted   = aborted;
	end

endmodule

// ==== rtl/step_gen.sv ====
`timescale 1ns/1ps
`include "motor_defs.svh"

module step_gen
	import motor_pkg::*;
(
	input  logic                           clk,
	input  logic                           resetn,

	input  logic                           start,
	input  logic                           stop,
	input  move_req_t                      req,
	output logic                           running,
	output logic                           limit_stop,

	output logic                           step_pulse,
	output logic                           step_dir,
	input  logic                           home_limit,
	input  logic                           end_limit,
	output logic signed [`MOTOR_POS_W-1:0] position
);

	logic [`MOTOR_SPEED_W-1:0] eff_speed;
	logic [`MOTOR_SPEED_W-1:0] period;
	logic [`MOTOR_SPEED_W-1:0] timer;
	logic [`MOTOR_STEP_W-1:0]  remain;
	logic                      limit_act;
	logic                      expire;
	logic                      fire;

	// periods below two cycles are clamped.
	assign eff_speed = (req.speed < `MOTOR_SPEED_W'(2)) ? `MOTOR_SPEED_W'(2) : req.speed;

	assign limit_act = step_dir ? home_limit : end_limit; // limit ahead of travel.
	assign expire    = running && (remain != '0) && (timer == '0);
	assign fire      = expire && !limit_act && !stop;

	// --------------------------------------------------------------------------
	// period timer and remaining steps.
	// --------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (start) begin
			period <= eff_speed;
			timer  <= eff_speed - 1'b1;
			remain <= req.steps;
		end else if (running) begin
			if (timer == '0)
				timer <= period - 1'b1;
			else
				timer <= timer - 1'b1;
			if (fire)
				remain <= remain - 1'b1;
		end
	end

	// --------------------------------------------------------------------------
	// run control, pulse output and position.
	// --------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!resetn) begin
			running    <= 1'b0;
			limit_stop <= 1'b0;
			step_pulse <= 1'b0;
			step_dir   <= 1'b0;
			position   <= '0;
		end else begin
			step_pulse <= fire;
			limit_stop <= expire && limit_act && !stop;
			if (stop) begin
				running <= 1'b0; // abort, no further pulses.
			end else if (start) begin
				running  <= 1'b1;
				step_dir <= req.dir;
			end else if (running && ((remain == '0) || (expire && limit_act))) begin
				running <= 1'b0;
			end
			if (fire)
				position <= step_dir ? position - 1'b1 : position + 1'b1;
		end
	end

endmodule

// ==== sim/motor_props.sv ====
`timescale 1ns/1ps

module motor_props (
	input logic clk,
	input logic resetn,
	input logic wb_ack,
	input logic step_pulse,
	input logic step_dir,
	input logic home_limit,
	input logic end_limit,
	input logic running,
	input logic start
);

	logic limit_ahead;

	assign limit_ahead = step_dir ? home_limit : end_limit; // limit in the direction of travel.

	ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held high for more than one cycle");

	pulse_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		step_pulse |=> !step_pulse)
		else $error("step_pulse held high for more than one cycle");

	no_pulse_on_limit: assert property (@(posedge clk) disable iff (!resetn)
		step_pulse |-> !limit_ahead)
		else $error("step pulse issued toward an active limit switch");

	run_needs_start: assert property (@(posedge clk) disable iff (!resetn)
		$rose(running) |-> $past(start))
		else $error("running rose without a start pulse");

endmodule

bind motor_top motor_props u_props (
	.clk        (clk),
	.resetn     (resetn),
	.wb_ack     (wb_ack),
	.step_pulse (step_pulse),
	.step_dir   (step_dir),
	.home_limit (home_limit),
	.end_limit  (end_limit),
	.running    (running),
	.start      (start)
);

// ==== sim/tb_motor_top.sv ====
`timescale 1ns/1ps
`include "motor_defs.svh"

module tb_motor_top
	import motor_pkg::*;
();

	localparam move_status_t st_busy  = 4'b1000;
	localparam move_status_t st_done  = 4'b0100; // done with no cause bits.
	localparam move_status_t st_limit = 4'b0110;
	localparam move_status_t st_abort = 4'b0101;

	logic                           clk;
	logic                           resetn;
	logic                           wb_cyc, wb_stb, wb_we;
	logic [`WB_ADR_W-1:0]           wb_adr;
	logic [`WB_DAT_W-1:0]           wb_dat_w;
	logic [`WB_DAT_W-1:0]           wb_dat_r;
	logic                           wb_ack;
	logic                           step_pulse, step_dir;
	logic                           home_limit, end_limit;

	logic [31:0]                    seed;
	logic signed [`MOTOR_POS_W-1:0] exp_pos;  // model of the axis position.
	logic                           exp_dir;
	int                             exp_period;
	int                             move_base;  // pulse count when the move began.
	int                             pulse_cnt = 0;
	int                             cycle_cnt = 0;
	int                             last_pulse = 0;

	motor_top u_motor_top (
		.clk        (clk),
		.resetn     (resetn),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.step_pulse (step_pulse),
		.step_dir   (step_dir),
		.home_limit (home_limit),
		.end_limit  (end_limit)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------------------------------------------------------------
	// error reporting and compare tasks.
	// --------------------------------------------------------------------------

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_status(input string name, input move_status_t got,
			input move_status_t exp);
		if (got !== exp)
			report_fail($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_position(input string name, input logic [`MOTOR_POS_W-1:0] got,
			input logic [`MOTOR_POS_W-1:0] exp);
		if (got !== exp)
			report_fail($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_word(input string name, input logic [`WB_DAT_W-1:0] got,
			input logic [`WB_DAT_W-1:0] exp);
		if (got !== exp)
			report_fail($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_fail($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	function automatic int pick(input int n); // lcg with the upper half of the state used.
		seed = seed * 32'd1664525 + 32'd1013904223;
		return int'(seed[31:16]) % n;
	endfunction

	// --------------------------------------------------------------------------
	// wishbone driver.
	// --------------------------------------------------------------------------

	task automatic bus_cycle(input logic we, input logic [`WB_ADR_W-1:0] adr,
			input logic [`WB_DAT_W-1:0] dat, output logic [`WB_DAT_W-1:0] rd);
		int n;
		n = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		do begin
			@(negedge clk);
			n++;
			if (n > 20)
				report_fail($sformatf("Timeout waiting for wb_ack at address %0d", adr));
		end while (!wb_ack);
		rd     = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_write(input logic [`WB_ADR_W-1:0] adr, input logic [`WB_DAT_W-1:0] dat);
		logic [`WB_DAT_W-1:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic bus_read(input logic [`WB_ADR_W-1:0] adr, output logic [`WB_DAT_W-1:0] rd);
		bus_cycle(1'b0, adr, '0, rd);
	endtask

	// --------------------------------------------------------------------------
	// move sequencing against the model.
	// --------------------------------------------------------------------------

	// each pulse is checked for direction and spacing.
	always @(negedge clk) begin
		cycle_cnt++;
		if (step_pulse) begin
			check_level("step_dir", step_dir, exp_dir);
			if (pulse_cnt != move_base)
				check_word("step interval", cycle_cnt - last_pulse, exp_period);
			last_pulse = cycle_cnt;
			pulse_cnt++;
		end
	end

	task automatic program_move(input logic dir, input int speed, input int steps);
		bus_write(REG_SPEED, speed);
		bus_write(REG_STEPS, steps);
		bus_write(REG_DIR, {31'd0, dir});
	endtask

	task automatic start_move(input logic dir, input int speed);
		logic [`WB_DAT_W-1:0] rd;
		exp_dir    = dir;
		exp_period = (speed < 2) ? 2 : speed;
		move_base  = pulse_cnt;
		bus_write(REG_CTRL, 32'h1);
		bus_read(REG_STATUS, rd);
		check_status("status after go", move_status_t'(rd[3:0]), st_busy);
	endtask

	// exp_pulses below zero takes the counted pulses, as after an abort.
	task automatic finish_move(input move_status_t exp_st, input int exp_pulses);
		logic [`WB_DAT_W-1:0] rd;
		move_status_t         st;
		int                   n;
		n = 0;
		do begin
			bus_read(REG_STATUS, rd);
			st = move_status_t'(rd[3:0]);
			n++;
			if (n > 300)
				report_fail("Timeout waiting for the done flag in STATUS");
		end while (!st.done);
		check_status("status", st, exp_st);
		if (exp_pulses < 0)
			exp_pulses = pulse_cnt - move_base;
		else
			check_word("pulse count", pulse_cnt - move_base, exp_pulses);
		exp_pos = exp_dir ? exp_pos - exp_pulses : exp_pos + exp_pulses;
		bus_read(REG_POSITION, rd);
		check_position("position", rd, exp_pos);
	endtask

	initial begin
		logic [`WB_DAT_W-1:0] rd;
		logic [`WB_DAT_W-1:0] w;
		logic                 dir;
		int                   speed;
		int                   steps;
		int                   steps2;
		resetn     = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		home_limit = 1'b0;
		end_limit  = 1'b0;
		seed       = 32'hce72_ea88;
		exp_pos    = '0;
		exp_dir    = 1'b0;
		exp_period = 2;
		move_base  = 0;
		repeat (10) @(negedge clk);
		resetn = 1'b1;

		// register map.
		bus_read(REG_STATUS, rd);
		check_word("STATUS after reset", rd, '0);
		bus_read(REG_POSITION, rd);
		check_word("POSITION after reset", rd, '0);
		w = pick(65536);
		w = (w << 16) | pick(65536);
		bus_write(REG_SPEED, w);
		bus_read(REG_SPEED, rd);
		check_word("SPEED", rd, `WB_DAT_W'(w[`MOTOR_SPEED_W-1:0]));
		bus_write(REG_STEPS, ~w);
		bus_read(REG_STEPS, rd);
		check_word("STEPS", rd, `WB_DAT_W'(w[`MOTOR_STEP_W-1:0] ^ {`MOTOR_STEP_W{1'b1}}));
		bus_write(REG_DIR, w);
		bus_read(REG_DIR, rd);
		check_word("DIR", rd, `WB_DAT_W'(w[0]));
		bus_read(REG_CTRL, rd);
		check_word("CTRL", rd, '0);
		for (int a = 6; a < 8; a++) begin
			bus_write(`WB_ADR_W'(a), w);
			bus_read(`WB_ADR_W'(a), rd);
			check_word("unmapped register", rd, '0);
		end

		// full moves with a limit possibly active behind the axis.
		for (int i = 0; i < 8; i++) begin
			dir        = (pick(2) == 1);
			speed      = 2 + pick(8);
			steps      = pick(21);
			home_limit = dir ? 1'b0 : (pick(2) == 1);
			end_limit  = dir ? (pick(2) == 1) : 1'b0;
			program_move(dir, speed, steps);
			start_move(dir, speed);
			finish_move(st_done, steps);
		end

		// moves toward an active limit.
		for (int i = 0; i < 2; i++) begin
			dir        = i[0];
			steps      = 1 + pick(20);
			home_limit = dir;
			end_limit  = !dir;
			program_move(dir, 2 + pick(8), steps);
			start_move(dir, 2);
			finish_move(st_limit, 0);
		end
		home_limit = 1'b0;
		end_limit  = 1'b0;

		for (int i = 0; i < 3; i++) begin
			dir   = (pick(2) == 1);
			speed = 2 + pick(8);
			program_move(dir, speed, 10 + pick(11));
			start_move(dir, speed);
			repeat (pick(8)) @(negedge clk);
			bus_write(REG_CTRL, 32'h2);
			finish_move(st_abort, -1);
		end

		// go while busy keeps the first request.
		dir    = (pick(2) == 1);
		speed  = 2 + pick(8);
		steps  = 10 + pick(11);
		steps2 = pick(21);
		program_move(dir, speed, steps);
		start_move(dir, speed);
		bus_write(REG_STEPS, steps2);
		bus_write(REG_CTRL, 32'h1);
		finish_move(st_done, steps);
		start_move(dir, speed);
		finish_move(st_done, steps2);

		$display("Verification passed");
		$finish;
	end

endmodule
